// ==== hdl/mm_config.svh ====
`ifndef MM_CONFIG_SVH
`define MM_CONFIG_SVH

// lane count, fixed by the two-level fold tree
`define MM_LANES 4

// lane index width
`define MM_LANE_W 2

// words per bank per run
`define MM_DEPTH 64

// elements summed into one lane result
`define MM_ROW_LEN 8

// word width of banks and lane results
`define MM_DATA_W 32

// bank address width
`define MM_ADDR_W 6

// checksum width
`define MM_OUT_W 4

`endif

// ==== hdl/mm_pkg.sv ====
`default_nettype none

`include "mm_config.svh"

package mm_pkg;

    // read request, kernel to bank
    typedef struct packed
    {
        logic                  en;
        logic [`MM_ADDR_W-1:0] addr;
    } ram_rd_t;

    // lane result, kernel to fold
    typedef struct packed
    {
        logic                  strobe;
        logic [`MM_DATA_W-1:0] data;
    } lane_wr_t;

    // bank load from outside
    // mat is 0 for A, 1 for B
    typedef struct packed
    {
        logic                  valid;
        logic                  mat;
        logic [`MM_LANE_W-1:0] lane;
        logic [`MM_ADDR_W-1:0] addr;
        logic [`MM_DATA_W-1:0] data;
    } load_req_t;

endpackage

`default_nettype wire

// ==== hdl/kernel_ram.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "mm_config.svh"

module kernel_ram
#(
    // {matrix select, lane}
    parameter int unsigned BANK_ID = 0
)
(
    input  wire                        ap_clk,
    input  wire                        arst_n,
    input  wire                        run_start,
    input  wire mm_pkg::load_req_t     load,
    input  wire mm_pkg::ram_rd_t       rd,
    output logic [`MM_DATA_W-1:0]      rd_data
);

    // two halves, indexed by {half, addr}
    logic [`MM_DATA_W-1:0] mem [2*`MM_DEPTH];

    // half that the kernel reads from
    logic active;

    logic load_hit;
    logic wr_half;

    // ############################
    // load side

    assign load_hit = load.valid &&
                      ({load.mat, load.lane} == (`MM_LANE_W+1)'(BANK_ID));

    // a load in the swap cycle lands in the half that is about to become shadow
    assign wr_half = run_start ? active : ~active;

    always_ff @(posedge ap_clk)
    begin
        if (load_hit)
        begin
            mem[{wr_half, load.addr}] <= load.data;
        end
    end

    // ############################
    // swap and read side

    always_ff @(posedge ap_clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            active <= 1'b0;
        end
        else if (run_start)
        begin
            active <= ~active;
        end
    end

    // one cycle read latency
    always_ff @(posedge ap_clk)
    begin
        if (rd.en)
        begin
            rd_data <= mem[{active, rd.addr}];
        end
    end

    // ############################
    // checks

    // loads must stay inside one half
    a_load_in_range: assert property (
        @(posedge ap_clk) disable iff (!arst_n)
        load_hit |-> (load.addr < `MM_DEPTH)
    );

endmodule

`default_nettype wire

// ==== hdl/mac_kernel.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "mm_config.svh"

module mac_kernel
(
    input  wire                                 ap_clk,
    input  wire                                 arst_n,
    input  wire                                 ap_start,
    input  wire [`MM_LANES-1:0][`MM_DATA_W-1:0] a_data,
    input  wire [`MM_LANES-1:0][`MM_DATA_W-1:0] b_data,
    output logic                                ap_done,
    output logic                                ap_idle,
    output logic                                run_start,
    output mm_pkg::ram_rd_t [`MM_LANES-1:0]     a_rd,
    output mm_pkg::ram_rd_t [`MM_LANES-1:0]     b_rd,
    output mm_pkg::lane_wr_t [`MM_LANES-1:0]    lane_wr
);

    import mm_pkg::*;

    localparam int ROW_W = $clog2(`MM_ROW_LEN);
    localparam logic [`MM_ADDR_W-1:0] ADDR_LAST = `MM_ADDR_W'(`MM_DEPTH - 1);

    typedef enum logic [1:0]
    {
        S_IDLE,
        S_ISSUE,
        S_DRAIN
    } state_t;

    state_t                state;
    logic [`MM_ADDR_W-1:0] addr_q;
    logic                  issue;
    ram_rd_t               rd_req;

    // flags delayed to line up with the read data
    logic vld_d;
    logic first_d;
    logic end_d;
    logic last_d;

    logic wr_strobe;
    logic done_pend;

    logic [`MM_DATA_W-1:0] prod     [`MM_LANES];
    logic [`MM_DATA_W-1:0] sum_next [`MM_LANES];
    logic [`MM_DATA_W-1:0] acc      [`MM_LANES];
    logic [`MM_DATA_W-1:0] wr_data  [`MM_LANES];

    // ############################
    // run control

    assign ap_idle   = (state == S_IDLE);
    assign run_start = ap_start && ap_idle;
    assign issue     = (state == S_ISSUE);

    always_ff @(posedge ap_clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            state  <= S_IDLE;
            addr_q <= '0;
        end
        else
        begin
            case (state)
                S_IDLE:
                begin
                    addr_q <= '0;
                    if (run_start)
                        state <= S_ISSUE;
                end
                S_ISSUE:
                begin
                    addr_q <= addr_q + 1'b1;
                    if (addr_q == ADDR_LAST)
                        state <= S_DRAIN;
                end
                S_DRAIN:
                begin
                    if (done_pend)
                        state <= S_IDLE;
                end
                default:
                begin
                    state <= S_IDLE;
                end
            endcase
        end
    end

    // all banks read the same address
    assign rd_req = '{en: issue, addr: addr_q};
    assign a_rd   = {`MM_LANES{rd_req}};
    assign b_rd   = {`MM_LANES{rd_req}};

    always_ff @(posedge ap_clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            vld_d     <= 1'b0;
            first_d   <= 1'b0;
            end_d     <= 1'b0;
            last_d    <= 1'b0;
            wr_strobe <= 1'b0;
            done_pend <= 1'b0;
            ap_done   <= 1'b0;
        end
        else
        begin
            vld_d     <= issue;
            first_d   <= (addr_q[ROW_W-1:0] == '0);
            end_d     <= (addr_q[ROW_W-1:0] == '1);
            last_d    <= (addr_q == ADDR_LAST);
            wr_strobe <= vld_d && end_d;
            done_pend <= vld_d && end_d && last_d;
            ap_done   <= done_pend;
        end
    end

    // ############################
    // lanes, no stall input so every element is consumed on arrival

    always_comb
    begin
        for (int i = 0; i < `MM_LANES; i++)
        begin
            prod[i]     = a_data[i] * b_data[i];
            sum_next[i] = (first_d ? '0 : acc[i]) + prod[i];
        end
    end

    always_ff @(posedge ap_clk)
    begin
        for (int i = 0; i < `MM_LANES; i++)
        begin
            if (vld_d)
                acc[i] <= sum_next[i];
            if (vld_d && end_d)
                wr_data[i] <= sum_next[i];
        end
    end

    always_comb
    begin
        for (int i = 0; i < `MM_LANES; i++)
        begin
            lane_wr[i].strobe = wr_strobe;
            lane_wr[i].data   = wr_data[i];
        end
    end

    a_done_when_idle: assert property (
        @(posedge ap_clk) disable iff (!arst_n)
        ap_done |-> ap_idle
    );

    a_write_in_run: assert property (
        @(posedge ap_clk) disable iff (!arst_n)
        wr_strobe |-> !ap_idle
    );

endmodule

`default_nettype wire

// ==== hdl/xor_fold.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "mm_config.svh"

module xor_fold
(
    input  wire                                 ap_clk,
    input  wire                                 arst_n,
    input  wire mm_pkg::lane_wr_t [`MM_LANES-1:0] lane_wr,
    output logic [`MM_OUT_W-1:0]                data_out,
    output logic                                data_valid
);

    localparam int BYTE_W = 8;

    logic [`MM_LANES-1:0] wr_vec;

    logic [`MM_LANES-1:0] v1;
    logic [BYTE_W-1:0]    x1 [`MM_LANES];
    logic [1:0]           v2;
    logic [BYTE_W-1:0]    x2 [2];
    logic                 v3;
    logic [BYTE_W-1:0]    x3;

    function automatic logic [BYTE_W-1:0] fold_word(input logic [`MM_DATA_W-1:0] w);
        logic [BYTE_W-1:0] r;
        r = '0;
        for (int b = 0; b < `MM_DATA_W / BYTE_W; b++)
            r = r ^ w[b*BYTE_W +: BYTE_W];
        return r;
    endfunction

    // 2-to-1 select/xor by valid mask
    function automatic logic [BYTE_W-1:0] pick_xor(input logic [1:0] v,
                                                   input logic [BYTE_W-1:0] lo,
                                                   input logic [BYTE_W-1:0] hi);
        case (v)
            2'b01:   return lo;
            2'b10:   return hi;
            2'b11:   return lo ^ hi;
            default: return '0;
        endcase
    endfunction

    always_comb
    begin
        for (int i = 0; i < `MM_LANES; i++)
            wr_vec[i] = lane_wr[i].strobe;
    end

    // ############################
    // valids

    always_ff @(posedge ap_clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            v1         <= '0;
            v2         <= '0;
            v3         <= 1'b0;
            data_valid <= 1'b0;
        end
        else
        begin
            v1         <= wr_vec;
            v2[0]      <= v1[0] | v1[1];
            v2[1]      <= v1[2] | v1[3];
            v3         <= |v2;
            data_valid <= v3;
        end
    end

    // ############################
    // data

    always_ff @(posedge ap_clk)
    begin
        for (int i = 0; i < `MM_LANES; i++)
            x1[i] <= fold_word(lane_wr[i].data);
        x2[0]    <= pick_xor(v1[1:0], x1[0], x1[1]);
        x2[1]    <= pick_xor(v1[3:2], x1[2], x1[3]);
        x3       <= pick_xor(v2, x2[0], x2[1]);
        data_out <= x3[BYTE_W-1:`MM_OUT_W] ^ x3[`MM_OUT_W-1:0];
    end

    a_valid_has_source: assert property (
        @(posedge ap_clk) disable iff (!arst_n)
        data_valid |-> $past(|wr_vec, 4)
    );

endmodule

`default_nettype wire

// ==== hdl/mm_wrapper.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "mm_config.svh"

module mm_wrapper
(
    input  wire                    ap_clk,
    input  wire                    arst_n,
    input  wire                    ap_start,
    input  wire mm_pkg::load_req_t load,
    output wire                    ap_done,
    output wire                    ap_idle,
    output wire [`MM_OUT_W-1:0]    data_out,
    output wire                    data_valid
);

    import mm_pkg::*;

    // first index is the matrix, 0 for A and 1 for B
    ram_rd_t  [1:0][`MM_LANES-1:0]                 bank_rd;
    wire      [1:0][`MM_LANES-1:0][`MM_DATA_W-1:0] bank_data;
    lane_wr_t [`MM_LANES-1:0]                      lane_wr;
    wire                                           run_start;

    // ############################
    // banks

    for (genvar m = 0; m < 2; m++)
    begin : g_mat
        for (genvar l = 0; l < `MM_LANES; l++)
        begin : g_lane
            kernel_ram #(
                .BANK_ID (m * `MM_LANES + l)
            ) bank_i (
                .ap_clk    (ap_clk),
                .arst_n    (arst_n),
                .run_start (run_start),
                .load      (load),
                .rd        (bank_rd[m][l]),
                .rd_data   (bank_data[m][l])
            );
        end
    end

    // ############################
    // compute and checksum

    mac_kernel kernel_i (
        .ap_clk    (ap_clk),
        .arst_n    (arst_n),
        .ap_start  (ap_start),
        .a_data    (bank_data[0]),
        .b_data    (bank_data[1]),
        .ap_done   (ap_done),
        .ap_idle   (ap_idle),
        .run_start (run_start),
        .a_rd      (bank_rd[0]),
        .b_rd      (bank_rd[1]),
        .lane_wr   (lane_wr)
    );

    xor_fold fold_i (
        .ap_clk     (ap_clk),
        .arst_n     (arst_n),
        .lane_wr    (lane_wr),
        .data_out   (data_out),
        .data_valid (data_valid)
    );

endmodule

`default_nettype wire

// ==== dv/mm_tb_model.svh ====
`ifndef MM_TB_MODEL_SVH
`define MM_TB_MODEL_SVH

// galois lfsr, x^32 + x^22 + x^2 + x + 1, shifting right
function automatic logic [31:0] lfsr_advance(input logic [31:0] s);
    if (s[0])
        return (s >> 1) ^ 32'h8020_0003;
    return s >> 1;
endfunction

// one multiply-accumulate step, wraps at 2^32
function automatic logic [`MM_DATA_W-1:0] dot_step(input logic [`MM_DATA_W-1:0] acc,
                                                   input logic [`MM_DATA_W-1:0] a,
                                                   input logic [`MM_DATA_W-1:0] b);
    logic [`MM_DATA_W-1:0] p;
    p = a * b;
    return acc + p;
endfunction

function automatic logic [7:0] byte_of_word(input logic [`MM_DATA_W-1:0] w);
    return w[31:24] ^ w[23:16] ^ w[15:8] ^ w[7:0];
endfunction

// checksum of one row over all lanes
function automatic logic [`MM_OUT_W-1:0] row_checksum(
    input logic [`MM_LANES-1:0][`MM_DATA_W-1:0] sums);
    logic [7:0] b;
    b = 8'h00;
    for (int l = 0; l < `MM_LANES; l++)
        b = b ^ byte_of_word(sums[l]);
    return b[7:4] ^ b[3:0];
endfunction

`endif

// ==== dv/mm_wrapper_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "mm_config.svh"

module mm_wrapper_tb;

    import mm_pkg::*;

    localparam int ROWS     = `MM_DEPTH / `MM_ROW_LEN;
    localparam int RUNS     = 6;
    localparam int ZERO_RUN = 3;
    localparam longint WATCHDOG_NS =
        RUNS * (2 * `MM_LANES * `MM_DEPTH + `MM_DEPTH + 40) * 100 * 2;

    logic                 ap_clk = 1'b0;
    logic                 arst_n;
    logic                 ap_start;
    load_req_t            load;
    logic                 ap_done;
    logic                 ap_idle;
    logic [`MM_OUT_W-1:0] data_out;
    logic                 data_valid;

    // indexed by matrix, lane, address
    logic [`MM_DATA_W-1:0] next_set [2][`MM_LANES][`MM_DEPTH];
    logic [`MM_DATA_W-1:0] cur_set  [2][`MM_LANES][`MM_DEPTH];
    logic                  next_zero;
    logic                  zero_run;
    logic                  start_expected;

    logic [`MM_OUT_W-1:0] exp_q [$];
    logic [31:0]          lfsr = 32'h0df6_d546;

    int cycle;
    int accept_cycle;
    int last_valid_cycle;
    int valid_count;
    int done_count;
    int checks;
    int errors;

    `include "mm_tb_model.svh"

    mm_wrapper mm_wrapper_i (
        .ap_clk     (ap_clk),
        .arst_n     (arst_n),
        .ap_start   (ap_start),
        .load       (load),
        .ap_done    (ap_done),
        .ap_idle    (ap_idle),
        .data_out   (data_out),
        .data_valid (data_valid)
    );

    always #50 ap_clk = ~ap_clk;

    always @(posedge ap_clk)
        cycle = cycle + 1;

    // ############################
    // check helpers

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        checks++;
        assert (actual === expected)
        else
        begin
            errors++;
            $display("FAILED at %0t: %s expected 0x%0h, got 0x%0h",
                     $time, name, expected, actual);
        end
    endtask

    task automatic check_true(input logic cond, input string what);
        checks++;
        assert (cond)
        else
        begin
            errors++;
            $display("error at %0t: %s", $time, what);
        end
    endtask

    task automatic draw_word(output logic [`MM_DATA_W-1:0] w);
        w = '0;
        for (int i = 0; i < `MM_DATA_W; i++)
        begin
            w    = {w[`MM_DATA_W-2:0], lfsr[0]};
            lfsr = lfsr_advance(lfsr);
        end
    endtask

    // ############################
    // stimulus

    // fills every bank's shadow half, one word per cycle
    task automatic load_dataset(input logic zero_a);
        logic [`MM_DATA_W-1:0] w;
        for (int m = 0; m < 2; m++)
            for (int l = 0; l < `MM_LANES; l++)
                for (int a = 0; a < `MM_DEPTH; a++)
                begin
                    draw_word(w);
                    if (zero_a && m == 0)
                        w = '0;
                    next_set[m][l][a] = w;
                    load <= '{valid: 1'b1, mat: 1'(m), lane: `MM_LANE_W'(l),
                              addr: `MM_ADDR_W'(a), data: w};
                    @(posedge ap_clk);
                end
        load      <= '0;
        next_zero  = zero_a;
    endtask

    // swap model datasets and queue the run's checksums
    task automatic take_dataset();
        logic [`MM_LANES-1:0][`MM_DATA_W-1:0] sums;
        cur_set  = next_set;
        zero_run = next_zero;
        for (int r = 0; r < ROWS; r++)
        begin
            for (int l = 0; l < `MM_LANES; l++)
            begin
                sums[l] = '0;
                for (int e = 0; e < `MM_ROW_LEN; e++)
                    sums[l] = dot_step(sums[l], cur_set[0][l][r * `MM_ROW_LEN + e],
                                       cur_set[1][l][r * `MM_ROW_LEN + e]);
            end
            exp_q.push_back(row_checksum(sums));
        end
    endtask

    task automatic wait_for_done();
        int n;
        n = 0;
        while (done_count == 0 && n < `MM_DEPTH + 16)
        begin
            @(posedge ap_clk);
            n++;
        end
        check_true(done_count != 0, "ap_done did not arrive within the run length");
    endtask

    task automatic wait_for_rows();
        int n;
        n = 0;
        while (valid_count < ROWS && n < 4 * `MM_ROW_LEN)
        begin
            @(posedge ap_clk);
            n++;
        end
        // room for any stray pulse to show up
        repeat (2 * `MM_ROW_LEN) @(posedge ap_clk);
    endtask

    // start already driven high, adds stray starts while busy
    task automatic drive_run();
        @(posedge ap_clk);
        ap_start <= 1'b0;
        repeat (19) @(posedge ap_clk);
        ap_start <= 1'b1;
        @(posedge ap_clk);
        ap_start <= 1'b0;
        repeat (42) @(posedge ap_clk);
        ap_start <= 1'b1;
        @(posedge ap_clk);
        ap_start <= 1'b0;
        wait_for_done();
        wait_for_rows();
    endtask

    // ############################
    // monitor, mid-cycle sampling

    always @(negedge ap_clk)
    begin
        logic [`MM_OUT_W-1:0] expected;
        if (arst_n)
        begin
            // only the start that opens a run counts as accepted
            if (ap_start && start_expected)
            begin
                accept_cycle   = cycle;
                start_expected = 1'b0;
            end
            if (data_valid)
            begin
                if (valid_count > 0)
                    check_value("data_valid spacing", `MM_ROW_LEN, cycle - last_valid_cycle);
                last_valid_cycle = cycle;
                valid_count++;
                check_true(exp_q.size() > 0, "data_valid arrived with no checksum pending");
                if (exp_q.size() > 0)
                begin
                    expected = exp_q.pop_front();
                    check_value("data_out", expected, data_out);
                end
                if (zero_run)
                    check_value("data_out", 0, data_out);
            end
            if (ap_done)
            begin
                done_count++;
                check_value("ap_done latency", `MM_DEPTH + 3, cycle - accept_cycle);
                check_true(ap_idle, "ap_done pulsed while ap_idle was low");
            end
        end
    end

    // ############################
    // main sequence

    initial
    begin
        arst_n         = 1'b0;
        ap_start       = 1'b0;
        load           = '0;
        next_zero      = 1'b0;
        zero_run       = 1'b0;
        start_expected = 1'b0;
        checks         = 0;
        errors         = 0;
        repeat (16) @(posedge ap_clk);
        arst_n <= 1'b1;

        repeat (4)
        begin
            @(negedge ap_clk);
            check_value("ap_idle", 1, ap_idle);
            check_value("ap_done", 0, ap_done);
            check_value("data_valid", 0, data_valid);
        end

        @(posedge ap_clk);
        load_dataset(1'b0);

        for (int r = 0; r < RUNS; r++)
        begin
            @(posedge ap_clk);
            ap_start       <= 1'b1;
            start_expected  = 1'b1;
            valid_count     = 0;
            done_count      = 0;
            take_dataset();
            // next dataset goes in while this run computes
            fork
                drive_run();
                if (r < RUNS - 1)
                    load_dataset(r + 1 == ZERO_RUN);
            join
            @(negedge ap_clk);
            check_value("data_valid count", ROWS, valid_count);
            check_value("ap_done count", 1, done_count);
            check_value("pending checksums", 0, exp_q.size());
            check_value("ap_idle", 1, ap_idle);
        end

        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0)
            $display("Done: no errors");
        else
            $display("Done: errors found");
        $finish;
    end

    // watchdog
    initial
    begin
        #(WATCHDOG_NS);
        $display("timeout: simulation still running after %0d ns, %0d errors so far",
                 WATCHDOG_NS, errors);
        $display("Done: errors found");
        $finish;
    end

endmodule

`default_nettype wire

// ==== verilog.f ====
+incdir+hdl
+incdir+dv
hdl/mm_pkg.sv
hdl/kernel_ram.sv
hdl/mac_kernel.sv
hdl/xor_fold.sv
hdl/mm_wrapper.sv
dv/mm_wrapper_tb.sv

// ==== Bender.yml ====
package:
  name: mm_wrapper

export_include_dirs:
  - hdl

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/mm_pkg.sv
      - hdl/kernel_ram.sv
      - hdl/mac_kernel.sv
      - hdl/xor_fold.sv
      - hdl/mm_wrapper.sv
  - target: test
    include_dirs:
      - hdl
      - dv
    files:
      - dv/mm_wrapper_tb.sv
